// File: xt_peripheral_glue.f
source/xt_bus_pkg.sv
source/ems_pkg.sv
source/xt_io_decoder.sv
source/ems_page_mapper.sv
source/misc_port_registers.sv
source/bus_readback.sv
source/timer_clock_divider.sv
source/xt_peripheral_glue.sv
dv/xt_peripheral_glue_chk.sv
dv/xt_peripheral_glue_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the glue testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module xt_peripheral_glue_tb -f xt_peripheral_glue.f -o xt_glue_sim \
    || { echo "build failed"; exit 1; }

./obj_dir/xt_glue_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -qx "TEST RESULT: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: dv/xt_peripheral_glue_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the XT peripheral glue.
// Runs CPU bus cycles against a shadow
// model and prints a summary per test.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module xt_peripheral_glue_tb;

    localparam int CLOCK_PERIOD  = 40;
    localparam int ACC_IO_WRITE  = 0;
    localparam int ACC_IO_READ   = 1;
    localparam int ACC_MEM_READ  = 2;
    localparam int ACC_MEM_WRITE = 3;
    localparam int LPT_ROUNDS    = 8;
    localparam int NMI_ROUNDS    = 8;
    localparam int EMS_ROUNDS    = 24;
    localparam int HIT_PROBES    = 10;
    localparam int TIMER_PULSES  = 12;
    localparam int BUS_CYCLES    = 6 + 2 * (LPT_ROUNDS + NMI_ROUNDS) + 3
                                   + 2 * EMS_ROUNDS + 6 + 4 * (4 + HIT_PROBES);
    localparam int WATCHDOG_CLOCKS = BUS_CYCLES * 5 + TIMER_PULSES * 6 + 16 + 200;

    logic                  clock = 1'b0;
    logic                  reset = 1'b1;
    xt_bus_pkg::bus_addr_t address_i = '0;
    xt_bus_pkg::bus_data_t data_i = '0;
    logic                  io_read_n_i = 1'b1;
    logic                  io_write_n_i = 1'b1;
    logic                  memory_read_n_i = 1'b1;
    logic                  memory_write_n_i = 1'b1;
    logic                  address_enable_n_i = 1'b1;
    logic                  tandy_video_i = 1'b1;
    logic                  ems_enabled_i = 1'b1;
    ems_pkg::ems_frame_t   ems_frame_i = '0;
    logic                  peripheral_clock_i = 1'b0;
    xt_bus_pkg::bus_data_t data_o;
    logic                  data_valid_o;
    logic [3:0]            ems_bank_hit_o;
    logic                  timer_clock_o;

    // Shadow registers start at their reset values
    logic [6:0]  shadow_map [4] = '{default: 7'h00};
    logic [3:0]  shadow_enable = 4'h0;
    logic [7:0]  shadow_lpt = 8'hFF;
    logic [7:0]  shadow_nmi = 8'hFF;

    logic [31:0] lfsr_state = 32'hc2f3266f;
    string       current_test = "";
    string       name_q [$];
    logic [15:0] expected_q [$];
    logic [15:0] actual_q [$];
    int          check_count = 0;
    int          error_count = 0;
    int          test_count = 0;
    int          checks_mark = 0;
    int          errors_mark = 0;
    int          toggle_count = 0;
    logic        timer_level_seen = 1'b0;

    xt_peripheral_glue xt_peripheral_glue_inst (.*);

    bind xt_peripheral_glue xt_peripheral_glue_chk glue_chk_inst (
        .clock         (clock),
        .reset         (reset),
        .data_i        (data_o),
        .data_valid_i  (data_valid_o),
        .bank_hit_i    (ems_bank_hit_o),
        .timer_clock_i (timer_clock_o)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    initial begin
        #(WATCHDOG_CLOCKS * CLOCK_PERIOD);
        $display("ERROR: watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [3:0] frame_code_for(input logic [1:0] frame);
        case (frame)
            2'd0:    return 4'hA;
            2'd1:    return 4'hC;
            default: return 4'hD;
        endcase
    endfunction

    // Returns {drive, byte} for I/O reads and the hit vector for memory cycles
    function automatic logic [8:0] reference_access(input int kind,
                                                    input logic [19:0] address,
                                                    input logic [7:0] data);
        logic [15:0] port;
        logic [1:0]  page;
        logic        is_ems;
        logic        is_lpt;
        logic        is_nmi;
        logic [8:0]  result;
        port = address[15:0];
        page = address[1:0];
        is_ems = ems_enabled_i && port >= xt_bus_pkg::EMS_PORT_BASE
            && port <= xt_bus_pkg::EMS_PORT_BASE + 16'd3;
        is_lpt = port == xt_bus_pkg::LPT_PORT;
        is_nmi = tandy_video_i && port >= xt_bus_pkg::NMI_MASK_BASE
            && port <= xt_bus_pkg::NMI_MASK_BASE + 16'd7;
        result = '0;
        if (kind == ACC_IO_WRITE) begin
            if (is_ems && data == 8'hFF) begin
                shadow_enable[page] = 1'b0;
            end else if (is_ems && data < 8'h80) begin
                shadow_map[page] = data[6:0];
                shadow_enable[page] = 1'b1;
            end
            if (is_lpt) shadow_lpt = data;
            if (is_nmi) shadow_nmi = data;
        end else if (kind == ACC_IO_READ) begin
            if (is_ems) result = {1'b1, shadow_enable[page] ? {1'b0, shadow_map[page]} : 8'hFF};
            else if (is_lpt) result = {1'b1, shadow_lpt};
            else if (is_nmi) result = {1'b1, shadow_nmi};
        end else begin
            for (int k = 0; k < 4; k++) begin
                result[k] = shadow_enable[k] && address[19:16] == frame_code_for(ems_frame_i)
                    && address[15:14] == 2'(k);
            end
        end
        return result;
    endfunction

    task automatic compare_values(input string name, input logic [15:0] expected,
                                  input logic [15:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic push_check(input logic [15:0] expected, input logic [15:0] actual);
        name_q.push_back(current_test);
        expected_q.push_back(expected);
        actual_q.push_back(actual);
    endtask

    // Enters and leaves 2 ns after a rising edge
    // Five clocks per bus cycle
    task automatic bus_cycle(input int kind, input logic [19:0] address,
                             input logic [7:0] data, output logic [8:0] read_value,
                             output logic [3:0] hits);
        address_i = address;
        data_i = data;
        address_enable_n_i = 1'b0;
        io_read_n_i = (kind != ACC_IO_READ);
        io_write_n_i = (kind != ACC_IO_WRITE);
        memory_read_n_i = (kind != ACC_MEM_READ);
        memory_write_n_i = (kind != ACC_MEM_WRITE);
        repeat (3) @(posedge clock);
        #1;
        read_value = {data_valid_o, data_o};
        hits = ems_bank_hit_o;
        #1;
        io_read_n_i = 1'b1;
        io_write_n_i = 1'b1;
        memory_read_n_i = 1'b1;
        memory_write_n_i = 1'b1;
        address_enable_n_i = 1'b1;
        repeat (2) begin
            @(posedge clock);
            #2;
        end
    endtask

    task automatic run_access(input int kind, input logic [19:0] address,
                              input logic [7:0] data);
        logic [8:0] expected;
        logic [8:0] read_value;
        logic [3:0] hits;
        expected = reference_access(kind, address, data);
        bus_cycle(kind, address, data, read_value, hits);
        if (kind == ACC_MEM_READ || kind == ACC_MEM_WRITE) begin
            push_check({12'h000, expected[3:0]}, {12'h000, hits});
        end else begin
            push_check({7'h00, expected}, {7'h00, read_value});
        end
    endtask

    task automatic start_test(input string name);
        current_test = name;
        checks_mark = check_count;
        errors_mark = error_count;
    endtask

    task automatic close_test();
        @(negedge clock);
        #1;
        test_count++;
        $display("test %s: %0d checks, %0d errors", current_test,
                 check_count - checks_mark, error_count - errors_mark);
        @(posedge clock);
        #2;
    endtask

    always @(negedge clock) begin : compare_queue
        string       name;
        logic [15:0] expected;
        logic [15:0] actual;
        while (name_q.size() > 0) begin
            name = name_q.pop_front();
            expected = expected_q.pop_front();
            actual = actual_q.pop_front();
            compare_values(name, expected, actual);
        end
    end

    always @(negedge clock) begin
        if (timer_clock_o !== timer_level_seen) toggle_count++;
        timer_level_seen = timer_clock_o;
    end

    initial begin : stimulus
        logic [31:0]           r;
        logic [31:0]           v;
        xt_bus_pkg::bus_addr_t address;
        repeat (16) @(posedge clock);
        #2;
        reset = 1'b0;

        start_test("reset_values");
        run_access(ACC_IO_READ, {4'h0, xt_bus_pkg::LPT_PORT}, 8'h00);
        run_access(ACC_IO_READ, {4'h0, xt_bus_pkg::NMI_MASK_BASE}, 8'h00);
        for (int p = 0; p < 4; p++) begin
            run_access(ACC_IO_READ, {4'h0, xt_bus_pkg::EMS_PORT_BASE[15:2], 2'(p)}, 8'h00);
        end
        close_test();

        start_test("lpt_nmi_readback");
        for (int i = 0; i < LPT_ROUNDS; i++) begin
            draw_bits(12, r);
            address = {r[3:0], xt_bus_pkg::LPT_PORT};
            run_access(ACC_IO_WRITE, address, r[11:4]);
            run_access(ACC_IO_READ, address, 8'h00);
        end
        for (int i = 0; i < NMI_ROUNDS; i++) begin
            draw_bits(18, r);
            run_access(ACC_IO_WRITE, {r[3:0], xt_bus_pkg::NMI_MASK_BASE[15:3], r[6:4]},
                       r[14:7]);
            run_access(ACC_IO_READ, {r[3:0], xt_bus_pkg::NMI_MASK_BASE[15:3], r[17:15]},
                       8'h00);
        end
        // Outside Tandy mode the mask port is absent
        tandy_video_i = 1'b0;
        run_access(ACC_IO_WRITE, {4'h0, xt_bus_pkg::NMI_MASK_BASE}, 8'h5A);
        run_access(ACC_IO_READ, {4'h0, xt_bus_pkg::NMI_MASK_BASE}, 8'h00);
        tandy_video_i = 1'b1;
        run_access(ACC_IO_READ, {4'h0, xt_bus_pkg::NMI_MASK_BASE}, 8'h00);
        close_test();

        start_test("ems_map_rules");
        for (int i = 0; i < EMS_ROUNDS; i++) begin
            draw_bits(14, r);
            v = (i % 6 == 5) ? 32'hFF : {24'h0, r[13:6]};
            address = {r[3:0], xt_bus_pkg::EMS_PORT_BASE[15:2], r[5:4]};
            run_access(ACC_IO_WRITE, address, v[7:0]);
            run_access(ACC_IO_READ, address, 8'h00);
        end
        ems_enabled_i = 1'b0;
        for (int p = 0; p < 4; p++) begin
            run_access(ACC_IO_READ, {4'h0, xt_bus_pkg::EMS_PORT_BASE[15:2], 2'(p)}, 8'h00);
        end
        run_access(ACC_IO_WRITE, {4'h0, xt_bus_pkg::EMS_PORT_BASE}, 8'h11);
        ems_enabled_i = 1'b1;
        run_access(ACC_IO_READ, {4'h0, xt_bus_pkg::EMS_PORT_BASE}, 8'h00);
        close_test();

        start_test("bank_hits");
        for (int f = 0; f < 4; f++) begin
            ems_frame_i = 2'(f);
            // One page per frame stays unmapped
            for (int p = 0; p < 4; p++) begin
                draw_bits(7, r);
                v = (p == f) ? 32'hFF : {25'h0, r[6:0]};
                run_access(ACC_IO_WRITE, {4'h0, xt_bus_pkg::EMS_PORT_BASE[15:2], 2'(p)},
                           v[7:0]);
            end
            // First pass over the pages reads, second pass writes
            for (int n = 0; n < HIT_PROBES; n++) begin
                draw_bits(20, r);
                address = (n < 8) ? {frame_code_for(2'(f)), 2'(n % 4), r[13:0]} : r[19:0];
                run_access(((n / 4) % 2 == 0) ? ACC_MEM_READ : ACC_MEM_WRITE, address,
                           r[7:0]);
            end
        end
        close_test();

        start_test("timer_clock");
        for (int i = 0; i < TIMER_PULSES; i++) begin
            peripheral_clock_i = 1'b1;
            repeat (3) @(posedge clock);
            #2;
            peripheral_clock_i = 1'b0;
            repeat (3) @(posedge clock);
            #2;
        end
        repeat (4) @(posedge clock);
        #2;
        push_check(16'(TIMER_PULSES), 16'(toggle_count));
        push_check(16'(TIMER_PULSES % 2), {15'h0000, timer_clock_o});
        close_test();

        @(negedge clock);
        #1;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d", test_count,
                 check_count, error_count, xt_peripheral_glue_inst.glue_chk_inst.failure_count);
        if (error_count == 0 && xt_peripheral_glue_inst.glue_chk_inst.failure_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: dv/xt_peripheral_glue_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent checks on the glue outputs,
// bound into the top level by the testbench.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module xt_peripheral_glue_chk (
    input logic                          clock,
    input logic                          reset,
    input xt_bus_pkg::bus_data_t         data_i,
    input logic                          data_valid_i,
    input logic [ems_pkg::EMS_PAGES-1:0] bank_hit_i,
    input logic                          timer_clock_i
);

    int failure_count = 0;

    // Released bus reads as zero
    idle_data_zero: assert property (@(posedge clock) disable iff (reset)
        !data_valid_i |-> data_i == '0)
    else begin
        $error("data_o is nonzero while data_valid_o is low");
        failure_count++;
    end

    // Pages never overlap inside the frame
    single_bank_hit: assert property (@(posedge clock) disable iff (reset)
        $onehot0(bank_hit_i))
    else begin
        $error("more than one EMS bank hit at once");
        failure_count++;
    end

    quiet_in_reset: assert property (@(posedge clock)
        reset |-> (!data_valid_i && bank_hit_i == '0 && !timer_clock_i))
    else begin
        $error("outputs active during reset");
        failure_count++;
    end

endmodule

// File: source/xt_peripheral_glue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XT peripheral I/O glue top level. Hooks
// the port decoder to the EMS, LPT and NMI
// registers, read-back and timer clock.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module xt_peripheral_glue (
    input  logic                          clock,
    input  logic                          reset,
    input  xt_bus_pkg::bus_addr_t         address_i,
    input  xt_bus_pkg::bus_data_t         data_i,
    input  logic                          io_read_n_i,
    input  logic                          io_write_n_i,
    input  logic                          memory_read_n_i,
    input  logic                          memory_write_n_i,
    input  logic                          address_enable_n_i,
    input  logic                          tandy_video_i,
    input  logic                          ems_enabled_i,
    input  ems_pkg::ems_frame_t           ems_frame_i,
    input  logic                          peripheral_clock_i,
    output xt_bus_pkg::bus_data_t         data_o,
    output logic                          data_valid_o,
    output logic [ems_pkg::EMS_PAGES-1:0] ems_bank_hit_o,
    output logic                          timer_clock_o
);

    logic                  ems_write_sel;
    logic                  ems_read_sel;
    logic                  lpt_write_sel;
    logic                  lpt_read_sel;
    logic                  nmi_write_sel;
    logic                  nmi_read_sel;
    xt_bus_pkg::bus_data_t ems_read_data;
    xt_bus_pkg::bus_data_t lpt_data;
    xt_bus_pkg::bus_data_t nmi_mask;

    xt_io_decoder xt_io_decoder_inst (
        .address_i          (address_i),
        .address_enable_n_i (address_enable_n_i),
        .io_read_n_i        (io_read_n_i),
        .io_write_n_i       (io_write_n_i),
        .tandy_video_i      (tandy_video_i),
        .ems_enabled_i      (ems_enabled_i),
        .ems_write_sel_o    (ems_write_sel),
        .ems_read_sel_o     (ems_read_sel),
        .lpt_write_sel_o    (lpt_write_sel),
        .lpt_read_sel_o     (lpt_read_sel),
        .nmi_write_sel_o    (nmi_write_sel),
        .nmi_read_sel_o     (nmi_read_sel)
    );

    ems_page_mapper ems_page_mapper_inst (
        .clock            (clock),
        .reset            (reset),
        .address_i        (address_i),
        .data_i           (data_i),
        .write_sel_i      (ems_write_sel),
        .memory_read_n_i  (memory_read_n_i),
        .memory_write_n_i (memory_write_n_i),
        .frame_i          (ems_frame_i),
        .read_data_o      (ems_read_data),
        .bank_hit_o       (ems_bank_hit_o)
    );

    misc_port_registers misc_port_registers_inst (
        .clock           (clock),
        .reset           (reset),
        .data_i          (data_i),
        .lpt_write_sel_i (lpt_write_sel),
        .nmi_write_sel_i (nmi_write_sel),
        .lpt_data_o      (lpt_data),
        .nmi_mask_o      (nmi_mask)
    );

    bus_readback bus_readback_inst (
        .clock          (clock),
        .reset          (reset),
        .ems_read_sel_i (ems_read_sel),
        .lpt_read_sel_i (lpt_read_sel),
        .nmi_read_sel_i (nmi_read_sel),
        .ems_data_i     (ems_read_data),
        .lpt_data_i     (lpt_data),
        .nmi_data_i     (nmi_mask),
        .data_o         (data_o),
        .data_valid_o   (data_valid_o)
    );

    timer_clock_divider timer_clock_divider_inst (
        .clock              (clock),
        .reset              (reset),
        .peripheral_clock_i (peripheral_clock_i),
        .timer_clock_o      (timer_clock_o)
    );

endmodule

// File: source/timer_clock_divider.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timer input clock, the peripheral clock
// synchronized and divided by two.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module timer_clock_divider (
    input  logic clock,
    input  logic reset,
    input  logic peripheral_clock_i,
    output logic timer_clock_o
);

    logic sync_meta;
    logic sync_q;
    logic sync_prev;
    logic timer_clock;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            sync_meta   <= 1'b0;
            sync_q      <= 1'b0;
            sync_prev   <= 1'b0;
            timer_clock <= 1'b0;
        end else begin
            sync_meta <= peripheral_clock_i;
            sync_q    <= sync_meta;
            sync_prev <= sync_q;
            if (sync_q && ~sync_prev) begin
                timer_clock <= ~timer_clock;
            end
        end
    end

    assign timer_clock_o = timer_clock;

endmodule

// File: source/bus_readback.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Registered read mux toward the CPU bus.
// Priority EMS, LPT, NMI; idles at zero
// with the drive flag low.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bus_readback (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  ems_read_sel_i,
    input  logic                  lpt_read_sel_i,
    input  logic                  nmi_read_sel_i,
    input  xt_bus_pkg::bus_data_t ems_data_i,
    input  xt_bus_pkg::bus_data_t lpt_data_i,
    input  xt_bus_pkg::bus_data_t nmi_data_i,
    output xt_bus_pkg::bus_data_t data_o,
    output logic                  data_valid_o
);

    xt_bus_pkg::bus_data_t read_data;
    logic                  read_valid;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            read_valid <= 1'b0;
            read_data  <= '0;
        end else if (ems_read_sel_i) begin
            read_valid <= 1'b1;
            read_data  <= ems_data_i;
        end else if (lpt_read_sel_i) begin
            read_valid <= 1'b1;
            read_data  <= lpt_data_i;
        end else if (nmi_read_sel_i) begin
            read_valid <= 1'b1;
            read_data  <= nmi_data_i;
        end else begin
            // Chipset releases the bus
            read_valid <= 1'b0;
            read_data  <= '0;
        end
    end

    assign data_o       = read_data;
    assign data_valid_o = read_valid;

endmodule

// File: source/misc_port_registers.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Parallel port data latch and Tandy NMI
// mask register, loaded on write select.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module misc_port_registers (
    input  logic                  clock,
    input  logic                  reset,
    input  xt_bus_pkg::bus_data_t data_i,
    input  logic                  lpt_write_sel_i,
    input  logic                  nmi_write_sel_i,
    output xt_bus_pkg::bus_data_t lpt_data_o,
    output xt_bus_pkg::bus_data_t nmi_mask_o
);

    xt_bus_pkg::bus_data_t lpt_data;
    xt_bus_pkg::bus_data_t nmi_mask;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_data <= xt_bus_pkg::IDLE_BYTE;
        end else if (lpt_write_sel_i) begin
            lpt_data <= data_i;
        end
    end

    // All NMI sources masked out of reset
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            nmi_mask <= xt_bus_pkg::IDLE_BYTE;
        end else if (nmi_write_sel_i) begin
            nmi_mask <= data_i;
        end
    end

    assign lpt_data_o = lpt_data;
    assign nmi_mask_o = nmi_mask;

endmodule

// File: source/ems_page_mapper.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four EMS page registers with a one-stage
// write capture, port read data and the
// memory window hit flags per page.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ems_page_mapper (
    input  logic                          clock,
    input  logic                          reset,
    input  xt_bus_pkg::bus_addr_t         address_i,
    input  xt_bus_pkg::bus_data_t         data_i,
    input  logic                          write_sel_i,
    input  logic                          memory_read_n_i,
    input  logic                          memory_write_n_i,
    input  ems_pkg::ems_frame_t           frame_i,
    output xt_bus_pkg::bus_data_t         read_data_o,
    output logic [ems_pkg::EMS_PAGES-1:0] bank_hit_o
);

    ems_pkg::ems_map_t           page_map [ems_pkg::EMS_PAGES];
    logic [ems_pkg::EMS_PAGES-1:0] page_enable;

    // Capture stage
    logic                  pend_write;
    ems_pkg::ems_index_t   pend_index;
    ems_pkg::ems_map_t     pend_map;
    logic                  pend_enable;

    ems_pkg::ems_index_t   port_index;
    logic                  unmap_value;
    logic                  map_value;
    ems_pkg::frame_code_t  frame_code;
    logic                  memory_strobe;

    assign port_index  = address_i[1:0];
    assign unmap_value = (data_i == ems_pkg::EMS_DISABLE_BYTE);
    assign map_value   = (data_i < ems_pkg::EMS_MAP_LIMIT);

    // Values 80h-FEh are ignored, so no update is queued for them
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            pend_write <= 1'b0;
        end else begin
            pend_write <= write_sel_i && (unmap_value || map_value);
        end
    end

    always_ff @(posedge clock) begin
        pend_index  <= port_index;
        pend_map    <= data_i[6:0];
        pend_enable <= map_value;
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int k = 0; k < ems_pkg::EMS_PAGES; k++) begin
                page_map[k] <= '0;
            end
            page_enable <= '0;
        end else if (pend_write) begin
            page_map[pend_index]    <= pend_map;
            page_enable[pend_index] <= pend_enable;
        end
    end

    assign read_data_o = page_enable[port_index] ? {1'b0, page_map[port_index]}
                                                 : xt_bus_pkg::IDLE_BYTE;

    always_comb begin
        case (frame_i)
            2'd0:    frame_code = ems_pkg::FRAME_CODE_A;
            2'd1:    frame_code = ems_pkg::FRAME_CODE_C;
            default: frame_code = ems_pkg::FRAME_CODE_D;
        endcase
    end

    assign memory_strobe = ~memory_read_n_i || ~memory_write_n_i;

    // Each page is a 16 KB slot inside the 64 KB frame
    always_comb begin
        for (int k = 0; k < ems_pkg::EMS_PAGES; k++) begin
            bank_hit_o[k] = memory_strobe && page_enable[k]
                && (address_i[19:14] == {frame_code, ems_pkg::ems_index_t'(k)});
        end
    end

endmodule

// File: source/xt_io_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I/O address decode for the glue's ports.
// Produces one read and one write select
// per register group, combinationally.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module xt_io_decoder (
    input  xt_bus_pkg::bus_addr_t address_i,
    input  logic                  address_enable_n_i,
    input  logic                  io_read_n_i,
    input  logic                  io_write_n_i,
    input  logic                  tandy_video_i,
    input  logic                  ems_enabled_i,
    output logic                  ems_write_sel_o,
    output logic                  ems_read_sel_o,
    output logic                  lpt_write_sel_o,
    output logic                  lpt_read_sel_o,
    output logic                  nmi_write_sel_o,
    output logic                  nmi_read_sel_o
);

    xt_bus_pkg::io_addr_t port_address;
    logic                 io_cycle;
    logic                 ems_hit;
    logic                 lpt_hit;
    logic                 nmi_hit;

    assign port_address = address_i[15:0];

    // DMA owns the bus while address enable is high
    assign io_cycle = ~address_enable_n_i;

    assign ems_hit = io_cycle && ems_enabled_i
        && (port_address[15:2] == xt_bus_pkg::EMS_PORT_BASE[15:2]);

    assign lpt_hit = io_cycle && (port_address == xt_bus_pkg::LPT_PORT);

    // NMI mask only exists on the Tandy
    assign nmi_hit = io_cycle && tandy_video_i
        && (port_address[15:3] == xt_bus_pkg::NMI_MASK_BASE[15:3]);

    assign ems_write_sel_o = ems_hit && ~io_write_n_i;
    assign ems_read_sel_o  = ems_hit && ~io_read_n_i;
    assign lpt_write_sel_o = lpt_hit && ~io_write_n_i;
    assign lpt_read_sel_o  = lpt_hit && ~io_read_n_i;
    assign nmi_write_sel_o = nmi_hit && ~io_write_n_i;
    assign nmi_read_sel_o  = nmi_hit && ~io_read_n_i;

endmodule

// File: source/ems_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// EMS page mapper types and constants.
// Page frame sits at A000h, C000h or D000h
// depending on the frame select input.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package ems_pkg;

    localparam int EMS_PAGES = 4;

    typedef logic [1:0] ems_index_t;

    // Bank number a page is mapped to
    typedef logic [6:0] ems_map_t;

    typedef logic [1:0] ems_frame_t;

    // Upper address nibble of the page frame
    typedef logic [3:0] frame_code_t;

    localparam frame_code_t FRAME_CODE_A = 4'hA;
    localparam frame_code_t FRAME_CODE_C = 4'hC;
    localparam frame_code_t FRAME_CODE_D = 4'hD;

    // Written to a page register to unmap it
    localparam xt_bus_pkg::bus_data_t EMS_DISABLE_BYTE = 8'hFF;

    // Written values below this map the page
    localparam xt_bus_pkg::bus_data_t EMS_MAP_LIMIT = 8'h80;

endpackage

// File: source/xt_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU bus types and the fixed I/O port map
// of the XT peripheral glue. Referenced by
// scoped names from the bus-facing modules.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package xt_bus_pkg;

    // 20-bit CPU address, memory and I/O cycles share it
    typedef logic [19:0] bus_addr_t;

    // I/O port number, lower 16 bits of the CPU address
    typedef logic [15:0] io_addr_t;

    typedef logic [7:0] bus_data_t;

    // Parallel port data latch
    localparam io_addr_t LPT_PORT = 16'h0378;

    // Tandy NMI mask, A0h-A7h, matched on bits 15:3
    localparam io_addr_t NMI_MASK_BASE = 16'h00A0;

    // EMS page registers, 260h-263h, matched on bits 15:2
    localparam io_addr_t EMS_PORT_BASE = 16'h0260;

    // Read value of an unmapped page, reset value of LPT and NMI mask
    localparam bus_data_t IDLE_BYTE = 8'hFF;

endpackage
